/* design/periph_pkg.sv */
// ======================================================================
// Shared types and codes for the peripheral bus block
// Access codes follow the core's active-low strobes (11 means idle)
// GPIO offsets are byte offsets within one 64-byte word slot
// ======================================================================
package periph_pkg;

    typedef logic [10:0] addr_t;       // Peripheral address, bit 10 picks the byte bank
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;       // Byte data and pin vectors
    typedef logic [1:0]  access_t;
    typedef logic [3:0]  slot_t;
    typedef logic [4:0]  func_sel_t;   // Top bit selects the byte bank
    typedef logic [15:0] slot_mask_t;

    localparam access_t ACC_NONE = 2'b11;
    localparam access_t ACC_BYTE = 2'b00;
    localparam access_t ACC_HALF = 2'b01;
    localparam access_t ACC_WORD = 2'b10;

    typedef struct packed {
        addr_t   addr;
        word_t   wdata;
        access_t write_n;
        access_t read_n;
    } bus_req_t;

    typedef struct packed {
        word_t data;
        logic  ready;
    } periph_rsp_t;

    // GPIO register map
    localparam logic [5:0] GPIO_OUT_OFS  = 6'h00;
    localparam logic [5:0] GPIO_IN_OFS   = 6'h04;
    localparam logic [5:0] AUDIO_SEL_OFS = 6'h10;

    // Pin select area: bit 5 set, bits 1:0 clear, bits 4:2 give the pin
    localparam logic [5:0] PIN_SEL_OFS  = 6'h20;
    localparam logic [5:0] PIN_SEL_MASK = 6'h23;

    // Pins leave reset driven by the GPIO slot, word bank slot 1
    localparam func_sel_t FUNC_SEL_RESET = 5'h01;

endpackage

/* design/periph_decode.sv */
// ======================================================================
// Address decode into word bank and byte bank selects
// Unoccupied slots read zero and are always ready
// Only the GPIO and PWM slots return data
// ======================================================================
`timescale 1ns/1ns

module periph_decode #(
    parameter int GPIO_SLOT = periph_pkg::FUNC_SEL_RESET,
    parameter int PWM_SLOT  = 5
) (
    input  periph_pkg::bus_req_t    i_req,
    input  periph_pkg::periph_rsp_t i_gpio_rsp,
    input  periph_pkg::byte_t       i_pwm_rdata,
    output periph_pkg::slot_mask_t  o_user_sel,
    output periph_pkg::slot_mask_t  o_simple_sel,
    output periph_pkg::periph_rsp_t o_rsp
);

    localparam periph_pkg::slot_t GPIO_S = periph_pkg::slot_t'(GPIO_SLOT);
    localparam periph_pkg::slot_t PWM_S  = periph_pkg::slot_t'(PWM_SLOT);

    logic              byte_bank;
    periph_pkg::slot_t user_slot;
    periph_pkg::slot_t simple_slot;

    assign byte_bank   = i_req.addr[10];
    assign user_slot   = i_req.addr[9:6];   // 64-byte word slots
    assign simple_slot = i_req.addr[7:4];   // 16-byte byte slots

    always_comb begin
        o_user_sel   = '0;
        o_simple_sel = '0;
        o_rsp.data   = '0;
        o_rsp.ready  = 1'b1;

        if (byte_bank) begin
            o_simple_sel[simple_slot] = 1'b1;
            // Byte peripherals are always ready
            if (simple_slot == PWM_S) begin
                o_rsp.data = {24'h0, i_pwm_rdata};
            end
        end else begin
            o_user_sel[user_slot] = 1'b1;
            if (user_slot == GPIO_S) begin
                o_rsp = i_gpio_rsp;
            end
        end
    end

    // Each bank select has at most one bit set
    always_comb begin
        a_sel_onehot: assert ($onehot0(o_user_sel) && $onehot0(o_simple_sel))
            else $error("periph_decode: select mask not one-hot");
    end

endmodule

/* design/gpio_regs.sv */
// ======================================================================
// GPIO slot: output register, input readback, pin function selects
// Function select codes use the decoder's slot numbering
// Unknown sources drive their pins low
// ======================================================================
`timescale 1ns/1ns

module gpio_regs #(
    parameter int GPIO_SLOT = periph_pkg::FUNC_SEL_RESET,
    parameter int PWM_SLOT  = 5
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  periph_pkg::bus_req_t    i_req,
    input  logic                    i_sel,
    input  periph_pkg::byte_t       i_ui_in,
    input  periph_pkg::byte_t       i_pwm_pins,
    output periph_pkg::periph_rsp_t o_rsp,
    output periph_pkg::byte_t       o_uo_out,
    output logic                    o_audio_select
);

    // Source codes as seen in a pin function select
    localparam periph_pkg::func_sel_t GPIO_FUNC = {1'b0, periph_pkg::slot_t'(GPIO_SLOT)};
    localparam periph_pkg::func_sel_t PWM_FUNC  = {1'b1, periph_pkg::slot_t'(PWM_SLOT)};

    periph_pkg::byte_t     gpio_out;
    periph_pkg::func_sel_t func_sel [8];
    logic [2:0]            audio_sel;
    logic [5:0]            ofs;
    logic                  wr_en;
    logic                  pin_area;
    logic [2:0]            pin_idx;

    assign ofs      = i_req.addr[5:0];
    assign wr_en    = i_sel && (i_req.write_n != periph_pkg::ACC_NONE);
    assign pin_area = (ofs & periph_pkg::PIN_SEL_MASK) == periph_pkg::PIN_SEL_OFS;
    assign pin_idx  = ofs[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out  <= '0;
            audio_sel <= '0;
            for (int i = 0; i < 8; i++) begin
                func_sel[i] <= GPIO_FUNC;
            end
        end else if (wr_en) begin
            if (ofs == periph_pkg::GPIO_OUT_OFS) gpio_out <= i_req.wdata[7:0];
            if (ofs == periph_pkg::AUDIO_SEL_OFS) audio_sel <= i_req.wdata[2:0];
            if (pin_area) func_sel[pin_idx] <= i_req.wdata[4:0];
        end
    end

    // Register readback, always ready
    always_comb begin
        o_rsp.ready = 1'b1;
        if (ofs == periph_pkg::GPIO_OUT_OFS) begin
            o_rsp.data = {24'h0, gpio_out};
        end else if (ofs == periph_pkg::GPIO_IN_OFS) begin
            o_rsp.data = {24'h0, i_ui_in};
        end else if (ofs == periph_pkg::AUDIO_SEL_OFS) begin
            o_rsp.data = {29'h0, audio_sel};
        end else if (pin_area) begin
            o_rsp.data = {27'h0, func_sel[pin_idx]};
        end else begin
            o_rsp.data = '0;
        end
    end

    // Each pin takes its own bit from the selected source
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            o_uo_out[i] = 1'b0;
            if (func_sel[i] == GPIO_FUNC) o_uo_out[i] = gpio_out[i];
            else if (func_sel[i] == PWM_FUNC) o_uo_out[i] = i_pwm_pins[i];
        end
    end

    assign o_audio_select = audio_sel[2];

    // Registers only move after a selected write with a real access code
    a_write_only: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(rst_n) && (gpio_out != $past(gpio_out) || audio_sel != $past(audio_sel)))
        |-> $past(i_sel && i_req.write_n != periph_pkg::ACC_NONE))
        else $error("gpio_regs: register changed without a write");

endmodule

/* design/pwm_periph.sv */
// ======================================================================
// Byte peripheral: 8-bit PWM with a free-running counter
// Duty 0 keeps the output low, duty 255 is high 255 of 256 cycles
// ======================================================================
`timescale 1ns/1ns

module pwm_periph (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_write,
    input  logic [3:0]        i_addr,
    input  periph_pkg::byte_t i_wdata,
    output periph_pkg::byte_t o_rdata,
    output periph_pkg::byte_t o_pins
);

    periph_pkg::byte_t duty;
    periph_pkg::byte_t count;
    logic              level;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            duty  <= '0;
            count <= '0;
        end else begin
            count <= count + 8'd1;                          // Wraps every 256 cycles
            if (i_write && i_addr == 4'h0) duty <= i_wdata;
        end
    end

    assign level   = count < duty;
    assign o_pins  = {8{level}};                            // Bit 7 doubles as audio
    assign o_rdata = (i_addr == 4'h0) ? duty : 8'h00;

endmodule

/* design/read_return.sv */
// ======================================================================
// Registered read return to the core
// Read data appears one cycle after the request and is held until
// the cycle after the core flags the read as complete
// ======================================================================
`timescale 1ns/1ns

module read_return (
    input  logic                    clk,
    input  logic                    rst_n,
    input  periph_pkg::access_t     i_read_n,
    input  periph_pkg::access_t     i_write_n,
    input  periph_pkg::periph_rsp_t i_rsp,
    input  logic                    i_data_read_complete,
    output periph_pkg::word_t       o_data_out,
    output logic                    o_data_ready
);

    logic              read_req;
    logic              capture;
    logic              hold;
    logic              ready_r;
    periph_pkg::word_t data_r;

    assign read_req = i_read_n != periph_pkg::ACC_NONE;
    assign capture  = !hold && i_rsp.ready && read_req;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_data_read_complete) hold <= 1'b0;
            if (capture) hold <= 1'b1;
            ready_r <= read_req && i_rsp.ready;   // Matches the data register latency
        end
    end

    always_ff @(posedge clk) begin
        if (capture) data_r <= i_rsp.data;
    end

    assign o_data_out   = data_r;
    assign o_data_ready = ready_r || (i_write_n != periph_pkg::ACC_NONE);

    // Held data survives until the core completes the read
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (hold && !i_data_read_complete) |=> (hold && $stable(o_data_out)))
        else $error("read_return: held data changed before completion");

endmodule

/* design/periph_top.sv */
// ======================================================================
// Peripheral bus block top level
// Word bank slot GPIO_SLOT holds the GPIO, byte bank slot PWM_SLOT
// holds the PWM; all other slots are empty
// ======================================================================
`timescale 1ns/1ns

module periph_top #(
    parameter int GPIO_SLOT = periph_pkg::FUNC_SEL_RESET,
    parameter int PWM_SLOT  = 5
) (
    input  logic                clk,
    input  logic                rst_n,
    input  periph_pkg::byte_t   i_ui_in,
    input  periph_pkg::addr_t   i_addr,
    input  periph_pkg::word_t   i_data_in,
    input  periph_pkg::access_t i_data_write_n,
    input  periph_pkg::access_t i_data_read_n,
    input  logic                i_data_read_complete,
    output periph_pkg::byte_t   o_uo_out,
    output logic                o_audio,
    output logic                o_audio_select,
    output periph_pkg::word_t   o_data_out,
    output logic                o_data_ready
);

    periph_pkg::bus_req_t    req;
    periph_pkg::slot_mask_t  user_sel;
    periph_pkg::slot_mask_t  simple_sel;
    periph_pkg::periph_rsp_t gpio_rsp;
    periph_pkg::periph_rsp_t dec_rsp;
    periph_pkg::byte_t       pwm_rdata;
    periph_pkg::byte_t       pwm_pins;
    logic                    pwm_write;

    assign req = '{addr: i_addr, wdata: i_data_in, write_n: i_data_write_n,
                   read_n: i_data_read_n};

    assign pwm_write = simple_sel[PWM_SLOT] && (i_data_write_n != periph_pkg::ACC_NONE);
    assign o_audio   = pwm_pins[7];

    periph_decode #(.GPIO_SLOT(GPIO_SLOT), .PWM_SLOT(PWM_SLOT)) u_decode (
        .i_req        (req),
        .i_gpio_rsp   (gpio_rsp),
        .i_pwm_rdata  (pwm_rdata),
        .o_user_sel   (user_sel),
        .o_simple_sel (simple_sel),
        .o_rsp        (dec_rsp)
    );

    gpio_regs #(.GPIO_SLOT(GPIO_SLOT), .PWM_SLOT(PWM_SLOT)) u_gpio (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_req          (req),
        .i_sel          (user_sel[GPIO_SLOT]),
        .i_ui_in        (i_ui_in),
        .i_pwm_pins     (pwm_pins),
        .o_rsp          (gpio_rsp),
        .o_uo_out       (o_uo_out),
        .o_audio_select (o_audio_select)
    );

    pwm_periph u_pwm (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_write (pwm_write),
        .i_addr  (i_addr[3:0]),
        .i_wdata (i_data_in[7:0]),
        .o_rdata (pwm_rdata),
        .o_pins  (pwm_pins)
    );

    read_return u_result (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_read_n             (i_data_read_n),
        .i_write_n            (i_data_write_n),
        .i_rsp                (dec_rsp),
        .i_data_read_complete (i_data_read_complete),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready)
    );

endmodule

/* sim/tb_periph_top.sv */
// ======================================================================
// Directed testbench for periph_top with GPIO in word slot 1, PWM in
// byte slot 5. Inputs change on the rising edge, outputs are sampled
// on the falling edge. Expected values come from the register map.
// ======================================================================
`timescale 1ns/1ns

module tb_periph_top;

    localparam int GPIO_SLOT = 1;
    localparam int PWM_SLOT  = 5;
    localparam periph_pkg::addr_t GPIO_BASE = 11'(GPIO_SLOT * 64);
    localparam periph_pkg::addr_t PWM_BASE  = 11'h400 | 11'(PWM_SLOT * 16);
    localparam periph_pkg::addr_t PIN_BASE  = GPIO_BASE + 11'h20;
    localparam periph_pkg::word_t PWM_FUNC  = 32'h10 | 32'(PWM_SLOT);  // Byte bank source
    localparam int NUM_TESTS = 6;
    localparam int READ_WAIT = 8;                   // Cycles allowed for data ready

    logic clk = 1'b0;
    logic rst_n;
    periph_pkg::byte_t   ui_in;
    periph_pkg::addr_t   addr;
    periph_pkg::word_t   data_in;
    periph_pkg::access_t write_n;
    periph_pkg::access_t read_n;
    logic                read_complete;
    periph_pkg::byte_t   uo_out;
    logic                audio;
    logic                audio_select;
    periph_pkg::word_t   data_out;
    logic                data_ready;

    int                value_errors = 0;
    int                protocol_errors = 0;
    int                seed;
    periph_pkg::byte_t gpio_val;                   // Last value written to the output register

    always #4 clk = ~clk;

    periph_top #(.GPIO_SLOT(GPIO_SLOT), .PWM_SLOT(PWM_SLOT)) uut (
        .clk(clk), .rst_n(rst_n), .i_ui_in(ui_in), .i_addr(addr), .i_data_in(data_in),
        .i_data_write_n(write_n), .i_data_read_n(read_n),
        .i_data_read_complete(read_complete), .o_uo_out(uo_out), .o_audio(audio),
        .o_audio_select(audio_select), .o_data_out(data_out), .o_data_ready(data_ready)
    );

    task automatic check_word(input string name, input periph_pkg::word_t got,
                              input periph_pkg::word_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Fail t=%0t %s: got 0x%h expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input periph_pkg::byte_t got,
                              input periph_pkg::byte_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("Fail t=%0t %s: got 0x%h expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("Fail t=%0t %s: got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic bus_write(input periph_pkg::addr_t a, input periph_pkg::word_t d);
        @(posedge clk);
        addr    <= a;
        data_in <= d;
        write_n <= periph_pkg::ACC_WORD;
        @(negedge clk);
        check_bit("o_data_ready on write", data_ready, 1'b1);
        @(posedge clk);
        write_n <= periph_pkg::ACC_NONE;
    endtask

    task automatic bus_read(input periph_pkg::addr_t a, output periph_pkg::word_t d);
        int n;
        n = 0;
        @(posedge clk);
        addr   <= a;
        read_n <= periph_pkg::ACC_WORD;
        do begin
            @(negedge clk);
            n++;
        end while (!data_ready && n < READ_WAIT);
        if (!data_ready) begin
            protocol_errors++;
            $display("Read of address 0x%h got no data ready within %0d cycles", a, n);
        end
        d = data_out;
        @(posedge clk);
        read_n        <= periph_pkg::ACC_NONE;
        read_complete <= 1'b1;
        @(posedge clk);
        read_complete <= 1'b0;
    endtask

    task automatic reset_state();
        periph_pkg::word_t d;
        @(negedge clk);
        check_byte("o_uo_out", uo_out, 8'h00);
        check_bit("o_audio_select", audio_select, 1'b0);
        check_bit("o_data_ready", data_ready, 1'b0);
        bus_read(GPIO_BASE + 11'(periph_pkg::GPIO_OUT_OFS), d);
        check_word("gpio_out", d, 32'h0);
        bus_read(GPIO_BASE + 11'(periph_pkg::AUDIO_SEL_OFS), d);
        check_word("audio_sel", d, 32'h0);
        for (int i = 0; i < 8; i++) begin
            bus_read(PIN_BASE + 11'(4 * i), d);
            check_word($sformatf("func_sel[%0d]", i), d, 32'(GPIO_SLOT));
        end
    endtask

    task automatic gpio_write_read();
        periph_pkg::word_t w;
        periph_pkg::word_t d;
        w = $random(seed);
        gpio_val = w[7:0];                         // Only the low byte is stored
        bus_write(GPIO_BASE + 11'(periph_pkg::GPIO_OUT_OFS), w);
        bus_read(GPIO_BASE + 11'(periph_pkg::GPIO_OUT_OFS), d);
        check_word("gpio_out", d, {24'h0, gpio_val});
        @(negedge clk);
        check_byte("o_uo_out", uo_out, gpio_val);
        w = $random(seed);
        @(posedge clk);
        ui_in <= w[7:0];
        bus_read(GPIO_BASE + 11'(periph_pkg::GPIO_IN_OFS), d);
        check_word("gpio_in", d, {24'h0, w[7:0]});
    endtask

    task automatic read_hold_timing();
        periph_pkg::byte_t first;
        periph_pkg::word_t d;
        first = 8'($random(seed));
        @(posedge clk);
        ui_in  <= first;
        addr   <= GPIO_BASE + 11'(periph_pkg::GPIO_IN_OFS);
        read_n <= periph_pkg::ACC_WORD;
        @(negedge clk);
        check_bit("o_data_ready in request cycle", data_ready, 1'b0);
        @(negedge clk);
        check_bit("o_data_ready one cycle later", data_ready, 1'b1);
        check_word("o_data_out", data_out, {24'h0, first});
        @(posedge clk);
        ui_in <= ~first;                           // Must not reach the held data
        repeat (3) begin
            @(negedge clk);
            check_word("o_data_out while held", data_out, {24'h0, first});
        end
        @(posedge clk);
        read_n        <= periph_pkg::ACC_NONE;
        read_complete <= 1'b1;
        @(posedge clk);
        read_complete <= 1'b0;
        @(negedge clk);
        check_bit("o_data_ready when idle", data_ready, 1'b0);
        gpio_val = 8'($random(seed));
        bus_write(GPIO_BASE + 11'(periph_pkg::GPIO_OUT_OFS), {24'h0, gpio_val});
        bus_read(GPIO_BASE + 11'(periph_pkg::GPIO_IN_OFS), d);
        check_word("gpio_in after release", d, {24'h0, ~first});
    endtask

    task automatic pwm_duty_count();
        periph_pkg::byte_t duty;
        periph_pkg::word_t d;
        int                high;
        duty = 8'($random(seed));
        high = 0;
        bus_write(PWM_BASE, {24'h0, duty});
        bus_read(PWM_BASE, d);
        check_word("pwm duty", d, {24'h0, duty});
        bus_read(PWM_BASE + 11'h4, d);
        check_word("pwm offset 4", d, 32'h0);
        repeat (256) begin
            @(negedge clk);
            if (audio) high++;
        end
        check_word("o_audio high cycles", 32'(high), {24'h0, duty});
    endtask

    task automatic pin_function_route();
        periph_pkg::word_t d;
        int                high;
        high = 0;
        bus_write(PIN_BASE + 11'(4 * 3), PWM_FUNC);
        bus_write(GPIO_BASE + 11'(periph_pkg::AUDIO_SEL_OFS), 32'h4);
        bus_write(PWM_BASE, 32'h80);               // Half duty
        bus_read(PIN_BASE + 11'(4 * 3), d);
        check_word("func_sel[3]", d, PWM_FUNC);
        repeat (256) begin
            @(negedge clk);
            check_byte("o_uo_out", uo_out, (gpio_val & 8'hF7) | {4'h0, audio, 3'h0});
            check_bit("o_audio_select", audio_select, 1'b1);
            if (uo_out[3]) high++;
        end
        check_word("pin 3 high cycles", 32'(high), 32'd128);
    endtask

    task automatic empty_slot_access();
        periph_pkg::word_t d;
        bus_read(11'h0C0, d);                      // Word slot 3
        check_word("empty word slot", d, 32'h0);
        bus_read(11'h420, d);                      // Byte slot 2
        check_word("empty byte slot", d, 32'h0);
        bus_write(11'h0C0, $random(seed));
        bus_read(GPIO_BASE + 11'(periph_pkg::GPIO_OUT_OFS), d);
        check_word("gpio_out after empty write", d, {24'h0, gpio_val});
    endtask

    // Watchdog sized from the test count
    initial begin
        repeat (NUM_TESTS * 600) @(posedge clk);
        $display("Watchdog expired after %0d cycles, run did not finish", NUM_TESTS * 600);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        seed = 32'h5201;
        rst_n = 1'b0;
        ui_in = 8'h00;
        addr = '0;
        data_in = '0;
        write_n = periph_pkg::ACC_NONE;
        read_n = periph_pkg::ACC_NONE;
        read_complete = 1'b0;
        gpio_val = 8'h00;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        reset_state();
        gpio_write_read();
        read_hold_timing();
        pwm_duty_count();
        pin_function_route();
        empty_slot_access();
        $display("Errors: %0d wrong values, %0d protocol failures",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* files.f */
design/periph_pkg.sv
design/periph_decode.sv
design/gpio_regs.sv
design/pwm_periph.sv
design/read_return.sv
design/periph_top.sv
sim/tb_periph_top.sv

/* Makefile */
# Verilator simulation of the peripheral bus block

VERILATOR ?= verilator
TOP       ?= tb_periph_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
